/* hw/dma_bench_settings.svh */
`ifndef DMA_BENCH_SETTINGS_SVH
`define DMA_BENCH_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// dma read bench widths
////////////////////////////////////////////////////////////////////////

// host byte address into pinned memory
`define DMA_ADDR_W 64

// transfer length in bytes
`define DMA_LEN_W 32

// one read data beat, 64 bytes
`define DMA_DATA_W 512
`define DMA_BEAT_BYTES_LOG2 6

// beat counters, cycle counters, pattern words
`define DMA_CNT_W 32

`endif

/* hw/dma_bench_pkg.sv */
`default_nettype none

`include "dma_bench_settings.svh"

package dma_bench_pkg;

	////////////////////////////////////////////////////////////////////////
	// host side records
	////////////////////////////////////////////////////////////////////////

	// written by the host, start is level, bench reacts to its rising edge
	typedef struct packed {
		logic [`DMA_ADDR_W-1:0] addr;
		logic [`DMA_LEN_W-1:0]  length;
		logic [`DMA_CNT_W-1:0]  offset;
		logic                   start;
	} bench_cfg_t;

	// read back by the host
	typedef struct packed {
		logic                  done;
		logic [`DMA_CNT_W-1:0] run_cnt;
		logic [`DMA_CNT_W-1:0] err_cnt;
		logic [`DMA_CNT_W-1:0] err_idx;
		logic [`DMA_CNT_W-1:0] th_cycles;
		logic [`DMA_CNT_W-1:0] lat_cycles;
	} bench_status_t;

	////////////////////////////////////////////////////////////////////////
	// dma engine side
	////////////////////////////////////////////////////////////////////////

	// read command, valid/ready
	typedef struct packed {
		logic                   valid;
		logic [`DMA_ADDR_W-1:0] address;
		logic [`DMA_LEN_W-1:0]  length;
	} dma_cmd_t;

	// read data, valid only
	typedef struct packed {
		logic                   valid;
		logic [`DMA_DATA_W-1:0] data;
	} dma_beat_t;

	// per-block results
	typedef struct packed {
		logic [`DMA_CNT_W-1:0] err_cnt;
		logic [`DMA_CNT_W-1:0] err_idx;
	} check_res_t;

	typedef struct packed {
		logic [`DMA_CNT_W-1:0] th_cycles;
		logic [`DMA_CNT_W-1:0] lat_cycles;
	} time_res_t;

	typedef enum logic [1:0] {
		run_idle = 2'd0,
		run_cmd  = 2'd1,
		run_data = 2'd2
	} run_state_e;

endpackage

`default_nettype wire

/* hw/dma_rd_seq.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module dma_rd_seq (
	input  wire                         pcie_clk,
	input  wire                         pcie_aresetn,
	input  wire dma_bench_pkg::bench_cfg_t cfg,
	output dma_bench_pkg::dma_cmd_t     rd_cmd,
	input  wire                         rd_cmd_ready,
	input  wire                         last_beat,
	output logic                        start_pulse,
	output logic                        cmd_fire,
	output logic                        running,
	output logic [`DMA_CNT_W-1:0]       last_idx
);

	// start synchronizer and edge register
	logic start_s1;
	logic start_s2;
	logic start_s3;

	dma_bench_pkg::run_state_e state;

	// command payload, latched at start
	logic [`DMA_ADDR_W-1:0] cmd_addr;
	logic [`DMA_LEN_W-1:0]  cmd_len;

	////////////////////////////////////////////////////////////////////////
	// start edge
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			start_s1 <= 1'b0;
			start_s2 <= 1'b0;
			start_s3 <= 1'b0;
		end else begin
			start_s1 <= cfg.start;
			start_s2 <= start_s1;
			start_s3 <= start_s2;
		end
	end

	// edges seen mid-run are dropped
	assign start_pulse = start_s2 & ~start_s3 & (state == dma_bench_pkg::run_idle);

	////////////////////////////////////////////////////////////////////////
	// run FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			state    <= dma_bench_pkg::run_idle;
			last_idx <= '0;
		end else begin
			case (state)
				dma_bench_pkg::run_idle: begin
					if (start_pulse) begin
						state    <= dma_bench_pkg::run_cmd;
						// index of final 64-byte beat
						last_idx <= `DMA_CNT_W'((cfg.length >> `DMA_BEAT_BYTES_LOG2) - 1'b1);
					end
				end
				dma_bench_pkg::run_cmd: begin
					if (cmd_fire) begin
						state <= dma_bench_pkg::run_data;
					end
				end
				dma_bench_pkg::run_data: begin
					if (last_beat) begin
						state <= dma_bench_pkg::run_idle;
					end
				end
				default: begin
					state <= dma_bench_pkg::run_idle;
				end
			endcase
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (start_pulse) begin
			cmd_addr <= cfg.addr;
			cmd_len  <= cfg.length;
		end
	end

	// one command per run, held until the engine takes it
	assign rd_cmd = '{valid: (state == dma_bench_pkg::run_cmd), address: cmd_addr,
		length: cmd_len};
	assign cmd_fire = rd_cmd.valid & rd_cmd_ready;
	assign running  = (state == dma_bench_pkg::run_data);

	// engine may stall, command must not move under it
	a_cmd_hold: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
		rd_cmd.valid && !rd_cmd_ready |=> rd_cmd.valid && $stable(rd_cmd));

endmodule

`default_nettype wire

/* hw/dma_rd_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module dma_rd_checker (
	input  wire                          pcie_clk,
	input  wire                          pcie_aresetn,
	input  wire dma_bench_pkg::dma_beat_t rd_data,
	input  wire                          running,
	input  wire                          start_pulse,
	input  wire [`DMA_CNT_W-1:0]         last_idx,
	input  wire [`DMA_CNT_W-1:0]         offset,
	output logic                         last_beat,
	output dma_bench_pkg::check_res_t    res
);

	logic [`DMA_CNT_W-1:0] beat_cnt;
	logic [`DMA_CNT_W-1:0] offset_q;
	logic [`DMA_CNT_W-1:0] err_cnt;
	logic [`DMA_CNT_W-1:0] err_idx;
	logic                  err_seen;

	logic                  beat_fire;
	logic                  mismatch;
	logic [`DMA_CNT_W-1:0] err_cnt_nxt;
	logic [`DMA_CNT_W-1:0] err_idx_nxt;

	// no back-pressure, every valid beat in a run counts
	assign beat_fire = rd_data.valid & running;
	assign last_beat = beat_fire & (beat_cnt == last_idx);

	// expected low word is index plus offset
	assign mismatch = beat_fire & (rd_data.data[31:0] != beat_cnt + offset_q);

	// totals including this cycle's beat
	assign err_cnt_nxt = err_cnt + `DMA_CNT_W'(mismatch);
	assign err_idx_nxt = (mismatch && !err_seen) ? beat_cnt : err_idx;

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			beat_cnt <= '0;
		end else if (start_pulse || last_beat) begin
			beat_cnt <= '0;
		end else if (beat_fire) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (start_pulse) begin
			offset_q <= offset;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// error tally, cleared per run
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn || start_pulse) begin
			err_cnt  <= '0;
			err_idx  <= '0;
			err_seen <= 1'b0;
		end else begin
			err_cnt  <= err_cnt_nxt;
			err_idx  <= err_idx_nxt;
			// first bad beat only
			err_seen <= err_seen | mismatch;
		end
	end

	assign res = '{err_cnt: err_cnt_nxt, err_idx: err_idx_nxt};

	// count wraps at last_idx set by the sequencer
	a_cnt_range: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
		beat_cnt <= last_idx);

endmodule

`default_nettype wire

/* hw/dma_rd_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module dma_rd_timer (
	input  wire                      pcie_clk,
	input  wire                      pcie_aresetn,
	input  wire                      start_pulse,
	input  wire                      cmd_fire,
	input  wire                      beat_valid,
	input  wire                      last_beat,
	output dma_bench_pkg::time_res_t res
);

	logic                  th_en;
	logic                  lat_en;
	logic [`DMA_CNT_W-1:0] th_cnt;
	logic [`DMA_CNT_W-1:0] lat_cnt;

	////////////////////////////////////////////////////////////////////////
	// window flags
	////////////////////////////////////////////////////////////////////////

	// throughput window, accepted command to last beat
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn || last_beat) begin
			th_en <= 1'b0;
		end else if (cmd_fire) begin
			th_en <= 1'b1;
		end
	end

	// latency window, accepted command to first beat
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn || beat_valid) begin
			lat_en <= 1'b0;
		end else if (cmd_fire) begin
			lat_en <= 1'b1;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn || start_pulse) begin
			th_cnt  <= '0;
			lat_cnt <= '0;
		end else begin
			th_cnt  <= th_cnt + `DMA_CNT_W'(th_en);
			lat_cnt <= lat_cnt + `DMA_CNT_W'(lat_en);
		end
	end

	// counts include the current cycle, so the end beat is in the total
	assign res = '{th_cycles: th_cnt + `DMA_CNT_W'(th_en),
		lat_cycles: lat_cnt + `DMA_CNT_W'(lat_en)};

	// first beat never comes after the last one
	a_lat_in_th: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
		lat_en |-> th_en);

endmodule

`default_nettype wire

/* hw/dma_rd_report.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_rd_report (
	input  wire                           pcie_clk,
	input  wire                           pcie_aresetn,
	input  wire                           start_pulse,
	input  wire                           last_beat,
	input  wire dma_bench_pkg::check_res_t chk,
	input  wire dma_bench_pkg::time_res_t  tim,
	output dma_bench_pkg::bench_status_t  status
);

	////////////////////////////////////////////////////////////////////////
	// status record seen by the host
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			status <= '0;
		end else if (start_pulse) begin
			// new run, old results go away
			status.done       <= 1'b0;
			status.err_cnt    <= '0;
			status.err_idx    <= '0;
			status.th_cycles  <= '0;
			status.lat_cycles <= '0;
		end else if (last_beat) begin
			// snapshot, held until next start
			status.done       <= 1'b1;
			status.run_cnt    <= status.run_cnt + 1'b1;
			status.err_cnt    <= chk.err_cnt;
			status.err_idx    <= chk.err_idx;
			status.th_cycles  <= tim.th_cycles;
			status.lat_cycles <= tim.lat_cycles;
		end
	end

endmodule

`default_nettype wire

/* hw/dma_rd_bench.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module dma_rd_bench (
	input  wire                           pcie_clk,
	input  wire                           pcie_aresetn,
	input  wire dma_bench_pkg::bench_cfg_t cfg,
	output dma_bench_pkg::dma_cmd_t       rd_cmd,
	input  wire                           rd_cmd_ready,
	input  wire dma_bench_pkg::dma_beat_t  rd_data,
	output dma_bench_pkg::bench_status_t  status
);

	logic                      start_pulse;
	logic                      cmd_fire;
	logic                      running;
	logic                      last_beat;
	logic [`DMA_CNT_W-1:0]     last_idx;
	dma_bench_pkg::check_res_t chk_res;
	dma_bench_pkg::time_res_t  tim_res;

	// start edge, command, run state
	dma_rd_seq seq0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.cfg          (cfg),
		.rd_cmd       (rd_cmd),
		.rd_cmd_ready (rd_cmd_ready),
		.last_beat    (last_beat),
		.start_pulse  (start_pulse),
		.cmd_fire     (cmd_fire),
		.running      (running),
		.last_idx     (last_idx)
	);

	// pattern compare on the beat stream
	dma_rd_checker chk0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.rd_data      (rd_data),
		.running      (running),
		.start_pulse  (start_pulse),
		.last_idx     (last_idx),
		.offset       (cfg.offset),
		.last_beat    (last_beat),
		.res          (chk_res)
	);

	dma_rd_timer tim0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.start_pulse  (start_pulse),
		.cmd_fire     (cmd_fire),
		.beat_valid   (rd_data.valid),
		.last_beat    (last_beat),
		.res          (tim_res)
	);

	dma_rd_report rep0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.start_pulse  (start_pulse),
		.last_beat    (last_beat),
		.chk          (chk_res),
		.tim          (tim_res),
		.status       (status)
	);

endmodule

`default_nettype wire

/* tb/tb_dma_rd_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module tb_dma_rd_monitor (
	input  wire                               pcie_clk,
	input  wire                               pcie_aresetn,
	input  wire dma_bench_pkg::bench_cfg_t    cfg,
	input  wire dma_bench_pkg::dma_cmd_t      rd_cmd,
	input  wire                               rd_cmd_ready,
	input  wire dma_bench_pkg::dma_beat_t     rd_data,
	input  wire dma_bench_pkg::bench_status_t status,
	output int                                tests_done,
	output int                                tests_failed,
	output int                                errors
);

	localparam int N_RUNS    = 5;
	localparam int MAX_BEATS = 32;

	int          cyc;
	int          runs;
	int          fire_cyc;
	int          nb_exp;
	int          nb_seen;
	logic [31:0] off;
	logic        collecting;
	logic        valid_q;
	logic        done_q;
	logic        reset_checked;
	logic        bad;
	logic [31:0] beat_word [0:MAX_BEATS-1];
	int          beat_cyc  [0:MAX_BEATS-1];

	dma_bench_pkg::bench_status_t exp_st;

	function automatic string test_name(input int n);
		case (n)
			0:       return "reset";
			1:       return "clean_run";
			2:       return "corrupt_beats";
			3:       return "delay_gaps";
			4:       return "back_to_back";
			5:       return "start_mid_run";
			default: return "extra_run";
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////

	// expected status from observed words and cycles
	function automatic dma_bench_pkg::bench_status_t expected_status(input int run);
		dma_bench_pkg::bench_status_t s;
		int                           i;
		s         = '0;
		s.done    = 1'b1;
		s.run_cnt = 32'(run);
		for (i = 0; i < nb_seen; i++) begin
			// low word should be index plus offset
			if (beat_word[i] != 32'(i) + off) begin
				if (s.err_cnt == 0)
					s.err_idx = 32'(i);
				s.err_cnt = s.err_cnt + 1;
			end
		end
		// both windows open the cycle after the handshake
		s.lat_cycles = 32'(beat_cyc[0] - fire_cyc);
		s.th_cycles  = 32'(beat_cyc[nb_seen-1] - fire_cyc);
		return s;
	endfunction

	task automatic check_field(input string test, input string field, input logic [63:0] exp,
		input logic [63:0] act);
		if (exp !== act) begin
			$display("Fail %s %s: expected %0d, actual %0d", test, field, exp, act);
			bad = 1'b1;
			errors++;
		end
	endtask

	task automatic check_status(input string test, input dma_bench_pkg::bench_status_t e);
		check_field(test, "done", 32'(e.done), 32'(status.done));
		check_field(test, "run_cnt", e.run_cnt, status.run_cnt);
		check_field(test, "err_cnt", e.err_cnt, status.err_cnt);
		check_field(test, "err_idx", e.err_idx, status.err_idx);
		check_field(test, "th_cycles", e.th_cycles, status.th_cycles);
		check_field(test, "lat_cycles", e.lat_cycles, status.lat_cycles);
	endtask

	task automatic finish_test(input string test);
		tests_done++;
		if (bad) begin
			tests_failed++;
			$display("%s: failed", test);
		end else begin
			$display("%s: passed", test);
		end
	endtask

	initial begin
		tests_done    = 0;
		tests_failed  = 0;
		errors        = 0;
		runs          = 0;
		reset_checked = 1'b0;
		bad           = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////
	// observe at the falling edge, all ports settled
	////////////////////////////////////////////////////////////////////////

	always @(negedge pcie_clk) begin
		if (!pcie_aresetn) begin
			cyc        = 0;
			valid_q    = 1'b0;
			done_q     = 1'b0;
			collecting = 1'b0;
		end else begin
			cyc++;
			// first cycle out of reset
			if (!reset_checked) begin
				bad    = 1'b0;
				exp_st = '0;
				check_status(test_name(0), exp_st);
				check_field(test_name(0), "rd_cmd.valid", 32'd0, 32'(rd_cmd.valid));
				finish_test(test_name(0));
				reset_checked = 1'b1;
			end
			// new command, old results must be cleared
			if (rd_cmd.valid && !valid_q) begin
				bad = 1'b0;
				if (runs >= N_RUNS) begin
					$display("A read command was issued after the last run had finished.");
					errors++;
				end
				exp_st         = '0;
				exp_st.run_cnt = 32'(runs);
				check_status(test_name(runs + 1), exp_st);
			end
			// handshake cycle, command carries the host address and length
			if (rd_cmd.valid && rd_cmd_ready) begin
				check_field(test_name(runs + 1), "rd_cmd.address", cfg.addr,
					rd_cmd.address);
				check_field(test_name(runs + 1), "rd_cmd.length", 64'(cfg.length),
					64'(rd_cmd.length));
				fire_cyc   = cyc;
				nb_exp     = int'(rd_cmd.length >> `DMA_BEAT_BYTES_LOG2);
				off        = cfg.offset;
				nb_seen    = 0;
				collecting = 1'b1;
			end
			if (rd_data.valid && collecting) begin
				if (nb_seen < MAX_BEATS) begin
					beat_word[nb_seen] = rd_data.data[31:0];
					beat_cyc[nb_seen]  = cyc;
				end
				nb_seen++;
			end
			// status latched a cycle after the last beat
			if (status.done && !done_q) begin
				runs++;
				collecting = 1'b0;
				if (nb_seen != nb_exp || nb_seen == 0) begin
					$display("%s saw %0d data beats where the command asked for %0d.",
						test_name(runs), nb_seen, nb_exp);
					bad = 1'b1;
					errors++;
				end else begin
					exp_st = expected_status(runs);
					check_status(test_name(runs), exp_st);
				end
				finish_test(test_name(runs));
			end
			valid_q = rd_cmd.valid;
			done_q  = status.done;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_dma_rd_bench.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dma_bench_settings.svh"

module tb_dma_rd_bench;

	localparam int N_RUNS    = 5;
	localparam int N_TESTS   = N_RUNS + 1;
	localparam int DRIVE_DLY = 2;

	logic                         pcie_clk;
	logic                         pcie_aresetn;
	dma_bench_pkg::bench_cfg_t    cfg;
	dma_bench_pkg::dma_cmd_t      rd_cmd;
	logic                         rd_cmd_ready;
	dma_bench_pkg::dma_beat_t     rd_data;
	dma_bench_pkg::bench_status_t status;

	logic [31:0] lfsr;
	int          cur_run;
	int          budget_cycles;
	int          tests_done;
	int          tests_failed;
	int          errors;

	// per-run stimulus, picked before reset
	int          n_beats    [1:N_RUNS];
	int          rdy_dly    [1:N_RUNS];
	int          gap_bits   [1:N_RUNS];
	int          first_wait [1:N_RUNS];
	logic [31:0] offs       [1:N_RUNS];
	logic [31:0] bad_mask   [1:N_RUNS];
	logic [63:0] addrs      [1:N_RUNS];

	////////////////////////////////////////////////////////////////////////
	// random source
	////////////////////////////////////////////////////////////////////////

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic plan_runs();
		int          t;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] idx;
		for (t = 1; t <= N_RUNS; t++) begin
			rdy_dly[t]    = 0;
			gap_bits[t]   = 0;
			first_wait[t] = 0;
			bad_mask[t]   = '0;
			hi            = take_bits(32);
			lo            = take_bits(26);
			addrs[t]      = {hi, lo[25:0], 6'd0};
			offs[t]       = take_bits(32);
		end
		// clean run
		n_beats[1] = 1 + int'(take_bits(4));
		// corrupted beats, at least one below index 8
		n_beats[2]  = 8 + int'(take_bits(3));
		idx         = take_bits(3);
		bad_mask[2] = take_bits(n_beats[2]);
		bad_mask[2][idx] = 1'b1;
		// ready delay and gaps
		n_beats[3]  = 1 + int'(take_bits(4));
		rdy_dly[3]  = int'(take_bits(3));
		gap_bits[3] = 2;
		bad_mask[3] = take_bits(n_beats[3]);
		// back to back
		n_beats[4]  = 1 + int'(take_bits(3));
		rdy_dly[4]  = int'(take_bits(2));
		gap_bits[4] = 1;
		bad_mask[4] = take_bits(n_beats[4]);
		// start toggled while the run waits for data
		n_beats[5]    = 1 + int'(take_bits(3));
		gap_bits[5]   = 1;
		first_wait[5] = 10;
	endtask

	////////////////////////////////////////////////////////////////////////
	// clock, DUT, monitor
	////////////////////////////////////////////////////////////////////////

	initial begin
		pcie_clk = 1'b0;
		forever #20 pcie_clk = ~pcie_clk;
	end

	dma_rd_bench dut0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.cfg          (cfg),
		.rd_cmd       (rd_cmd),
		.rd_cmd_ready (rd_cmd_ready),
		.rd_data      (rd_data),
		.status       (status)
	);

	tb_dma_rd_monitor mon0 (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.cfg          (cfg),
		.rd_cmd       (rd_cmd),
		.rd_cmd_ready (rd_cmd_ready),
		.rd_data      (rd_data),
		.status       (status),
		.tests_done   (tests_done),
		.tests_failed (tests_failed),
		.errors       (errors)
	);

	////////////////////////////////////////////////////////////////////////
	// dma engine model
	////////////////////////////////////////////////////////////////////////

	task automatic serve_command();
		int          t;
		int          nb;
		int          d;
		int          g;
		int          i;
		logic [31:0] word;
		do begin
			@(posedge pcie_clk);
			#DRIVE_DLY;
		end while (!rd_cmd.valid);
		t = cur_run;
		d = rdy_dly[t];
		while (d > 0) begin
			@(posedge pcie_clk);
			#DRIVE_DLY;
			d--;
		end
		rd_cmd_ready = 1'b1;
		nb = int'(rd_cmd.length >> `DMA_BEAT_BYTES_LOG2);
		@(posedge pcie_clk);
		#DRIVE_DLY;
		rd_cmd_ready = 1'b0;
		for (i = 0; i < nb; i++) begin
			g = int'(take_bits(gap_bits[t]));
			if (i == 0)
				g = g + first_wait[t];
			while (g > 0) begin
				@(posedge pcie_clk);
				#DRIVE_DLY;
				g--;
			end
			// pattern word, inverted on a chosen beat
			word = 32'(i) + offs[t];
			if (bad_mask[t][i])
				word = ~word;
			rd_data.valid = 1'b1;
			rd_data.data  = {16{word}};
			@(posedge pcie_clk);
			#DRIVE_DLY;
			rd_data.valid = 1'b0;
		end
	endtask

	initial begin
		rd_cmd_ready = 1'b0;
		rd_data      = '0;
		forever serve_command();
	end

	////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////

	task automatic do_run(input int t, input int idle, input logic toggle);
		cfg.start = 1'b0;
		repeat (idle) begin
			@(posedge pcie_clk);
			#DRIVE_DLY;
		end
		cur_run    = t;
		cfg.addr   = addrs[t];
		cfg.length = 32'(n_beats[t] * 64);
		cfg.offset = offs[t];
		cfg.start  = 1'b1;
		do begin
			@(posedge pcie_clk);
			#DRIVE_DLY;
		end while (!rd_cmd.valid);
		// second edge while busy
		if (toggle) begin
			cfg.start = 1'b0;
			repeat (2) begin
				@(posedge pcie_clk);
				#DRIVE_DLY;
			end
			cfg.start = 1'b1;
		end
		do begin
			@(posedge pcie_clk);
			#DRIVE_DLY;
		end while (!status.done);
	endtask

	initial begin
		int t;
		lfsr          = 32'h3ad8e9a6;
		cur_run       = 1;
		pcie_aresetn  = 1'b0;
		cfg           = '0;
		plan_runs();
		budget_cycles = 0;
		for (t = 1; t <= N_RUNS; t++)
			budget_cycles += 16 + rdy_dly[t] + first_wait[t] + n_beats[t] * (1 << gap_bits[t]);
		// margin over the worst case, plus reset and tail
		budget_cycles = budget_cycles * 4 + 40;
		repeat (2) @(posedge pcie_clk);
		#DRIVE_DLY;
		pcie_aresetn = 1'b1;
		do_run(1, 4, 1'b0);
		do_run(2, 4, 1'b0);
		do_run(3, 4, 1'b0);
		do_run(4, 1, 1'b0);
		do_run(5, 4, 1'b1);
		repeat (10) @(posedge pcie_clk);
		$display("%0d tests, %0d passed, %0d failed", tests_done, tests_done - tests_failed,
			tests_failed);
		if (errors == 0 && tests_failed == 0 && tests_done == N_TESTS)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial begin
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge pcie_clk);
		$display("Timeout: status done was not seen within %0d cycles.", budget_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/dma_bench_pkg.sv
hw/dma_rd_seq.sv
hw/dma_rd_checker.sv
hw/dma_rd_timer.sv
hw/dma_rd_report.sv
hw/dma_rd_bench.sv
tb/tb_dma_rd_monitor.sv
tb/tb_dma_rd_bench.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_dma_rd_bench
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
